// ==== common/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Data path and address width
`define XLEN 32

// Architectural register file size
`define NUM_REGS 32
`define REG_W 5

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// ==== common/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // ----------------------------------------------------------
    // Major opcodes of the supported RV32I subset
    // ----------------------------------------------------------
    typedef enum logic [6:0] {
        OPC_NOP    = 7'b0000000,
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    // ALU operations, carried down the pipe in the decoded record
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_e;

    // ----------------------------------------------------------
    // funct3 values
    // ----------------------------------------------------------
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_LW   = 3'b010;
    localparam logic [2:0] F3_SW   = 3'b010;
    localparam logic [2:0] F3_JALR = 3'b000;

    // funct7 values, SUB is the only one with bit 30 set
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

endpackage

// ==== common/pipe_pkg.sv ====
`include "core_settings.svh"

package pipe_pkg;
    import rv_isa_pkg::*;

    // Operand source for the execute stage, 2'b11 is never produced
    typedef enum logic [1:0] {
        FWD_IDEX = 2'b00,
        FWD_MEM  = 2'b01,
        FWD_WB   = 2'b10
    } fwd_sel_e;

    // Source register indices of one instruction
    typedef struct packed {
        logic [`REG_W-1:0] rs1;
        logic [`REG_W-1:0] rs2;
    } reg_use_t;

    // Destination register and its write enable
    typedef struct packed {
        logic [`REG_W-1:0] rd;
        logic              we;
    } reg_wr_t;

    // Control flags produced by the decoder
    typedef struct packed {
        logic use_imm;
        logic load;
        logic store;
        logic branch;
        logic bne;
        logic jal;
        logic jalr;
    } ctrl_t;

    // ----------------------------------------------------------
    // Stage records, valid low is a bubble and a bubble is zero
    // ----------------------------------------------------------
    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  pc;
        logic [`XLEN-1:0]  insn;
    } ifid_t;

    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  pc;
        reg_use_t          reg_use;
        reg_wr_t           reg_wr;
        logic [`XLEN-1:0]  rs1_val;
        logic [`XLEN-1:0]  rs2_val;
        logic [`XLEN-1:0]  imm;
        alu_op_e           alu_op;
        ctrl_t             ctrl;
    } idex_t;

    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  pc;
        reg_wr_t           reg_wr;
        logic [`XLEN-1:0]  result;
        logic [`XLEN-1:0]  store_data;
        logic              load;
        logic              store;
    } exmem_t;

    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  pc;
        reg_wr_t           reg_wr;
        logic [`XLEN-1:0]  value;
    } memwb_t;

    // Data memory request, driven straight from EX/MEM
    typedef struct packed {
        logic [`XLEN-1:0]  addr;
        logic [`XLEN-1:0]  wdata;
        logic              we;
        logic              re;
    } dmem_req_t;

    // One retired instruction
    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  pc;
        reg_wr_t           reg_wr;
        logic [`XLEN-1:0]  value;
    } retire_t;

endpackage

// ==== rtl/pipe_reg.sv ====
`timescale 1ns/1ps

module pipe_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst_n,
    input  logic hold,
    input  logic flush,
    input  T     d,
    output T     q
);

    // Bubble is the all-zero record
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else if (flush) begin
            // Flush beats hold so a redirect always clears the slot
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

// ==== rtl/decoder.sv ====
`timescale 1ns/1ps

`include "core_settings.svh"

module decoder
    import rv_isa_pkg::*, pipe_pkg::*;
(
    input  logic [`XLEN-1:0] insn,
    output reg_use_t         dec_use,
    output reg_wr_t          dec_wr,
    output logic [`XLEN-1:0] imm,
    output alu_op_e          alu_op,
    output ctrl_t            ctrl
);

    logic [`REG_W-1:0] rd;
    logic [`REG_W-1:0] rs1;
    logic [`REG_W-1:0] rs2;
    logic [2:0]        f3;
    logic [6:0]        f7;
    logic [`XLEN-1:0]  imm_i;
    logic [`XLEN-1:0]  imm_s;
    logic [`XLEN-1:0]  imm_b;
    logic [`XLEN-1:0]  imm_j;

    // Fixed instruction fields
    assign rd  = insn[11:7];
    assign rs1 = insn[19:15];
    assign rs2 = insn[24:20];
    assign f3  = insn[14:12];
    assign f7  = insn[31:25];

    // Sign extended immediates, B and J have an implicit zero LSB
    assign imm_i = {{(`XLEN-12){insn[31]}}, insn[31:20]};
    assign imm_s = {{(`XLEN-12){insn[31]}}, insn[31:25], insn[11:7]};
    assign imm_b = {{(`XLEN-13){insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    assign imm_j = {{(`XLEN-21){insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

    always_comb begin
        // Anything not matched below stays a no-write NOP
        dec_use = '0;
        dec_wr  = '0;
        imm     = '0;
        alu_op  = ALU_ADD;
        ctrl    = '0;

        case (insn[6:0])
            OPC_OP: begin
                dec_use.rs1 = rs1;
                dec_use.rs2 = rs2;
                dec_wr.rd   = rd;
                case ({f7, f3})
                    {F7_BASE, F3_ADD}: alu_op = ALU_ADD;
                    {F7_SUB,  F3_ADD}: alu_op = ALU_SUB;
                    {F7_BASE, F3_SLT}: alu_op = ALU_SLT;
                    {F7_BASE, F3_XOR}: alu_op = ALU_XOR;
                    {F7_BASE, F3_OR }: alu_op = ALU_OR;
                    {F7_BASE, F3_AND}: alu_op = ALU_AND;
                    default: begin
                        dec_use = '0;
                        dec_wr  = '0;
                    end
                endcase
            end
            OPC_OP_IMM: begin
                // Only ADDI is part of the subset
                if (f3 == F3_ADD) begin
                    dec_use.rs1  = rs1;
                    dec_wr.rd    = rd;
                    imm          = imm_i;
                    ctrl.use_imm = 1'b1;
                end
            end
            OPC_LOAD: begin
                if (f3 == F3_LW) begin
                    dec_use.rs1  = rs1;
                    dec_wr.rd    = rd;
                    imm          = imm_i;
                    ctrl.use_imm = 1'b1;
                    ctrl.load    = 1'b1;
                end
            end
            OPC_STORE: begin
                // rs2 is the store data and gets forwarded like any operand
                if (f3 == F3_SW) begin
                    dec_use.rs1  = rs1;
                    dec_use.rs2  = rs2;
                    imm          = imm_s;
                    ctrl.use_imm = 1'b1;
                    ctrl.store   = 1'b1;
                end
            end
            OPC_BRANCH: begin
                if (f3 == F3_BEQ || f3 == F3_BNE) begin
                    dec_use.rs1 = rs1;
                    dec_use.rs2 = rs2;
                    imm         = imm_b;
                    ctrl.branch = 1'b1;
                    ctrl.bne    = (f3 == F3_BNE);
                end
            end
            OPC_JAL: begin
                dec_wr.rd = rd;
                imm       = imm_j;
                ctrl.jal  = 1'b1;
            end
            OPC_JALR: begin
                if (f3 == F3_JALR) begin
                    dec_use.rs1 = rs1;
                    dec_wr.rd   = rd;
                    imm         = imm_i;
                    ctrl.jalr   = 1'b1;
                end
            end
            default: ;
        endcase

        // x0 destination never writes
        dec_wr.we = (dec_wr.rd != '0);
    end

endmodule

// ==== rtl/regfile.sv ====
`timescale 1ns/1ps

`include "core_settings.svh"

module regfile
    import pipe_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  reg_use_t         rd_use,
    output logic [`XLEN-1:0] rs1_val,
    output logic [`XLEN-1:0] rs2_val,
    input  reg_wr_t          wr,
    input  logic [`XLEN-1:0] wr_val
);

    // x0 has no storage
    logic [`XLEN-1:0] regs [1:`NUM_REGS-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.we && (wr.rd != '0)) begin
            regs[wr.rd] <= wr_val;
        end
    end

    // Reads see the old value during a same-cycle write
    assign rs1_val = (rd_use.rs1 == '0) ? '0 : regs[rd_use.rs1];
    assign rs2_val = (rd_use.rs2 == '0) ? '0 : regs[rd_use.rs2];

endmodule

// ==== rtl/execute_stage.sv ====
`timescale 1ns/1ps

`include "core_settings.svh"

module execute_stage
    import rv_isa_pkg::*, pipe_pkg::*;
(
    input  idex_t            idex,
    input  fwd_sel_e         rs1_sel,
    input  fwd_sel_e         rs2_sel,
    input  logic [`XLEN-1:0] mem_fwd,
    input  logic [`XLEN-1:0] wb_fwd,
    output exmem_t           exmem,
    output logic             redirect,
    output logic [`XLEN-1:0] target
);

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_b;
    logic [`XLEN-1:0] alu_res;
    logic [`XLEN-1:0] jalr_sum;
    logic [`XLEN-1:0] link;
    logic             equal;
    logic             taken;

    // ----------------------------------------------------------
    // Operand forwarding
    // ----------------------------------------------------------
    always_comb begin
        case (rs1_sel)
            FWD_MEM: op_a = mem_fwd;
            FWD_WB:  op_a = wb_fwd;
            default: op_a = idex.rs1_val;
        endcase
        // rs2 is also the store data
        case (rs2_sel)
            FWD_MEM: op_b = mem_fwd;
            FWD_WB:  op_b = wb_fwd;
            default: op_b = idex.rs2_val;
        endcase
    end

    // ----------------------------------------------------------
    // ALU, also forms the load and store address
    // ----------------------------------------------------------
    assign alu_b = idex.ctrl.use_imm ? idex.imm : op_b;

    always_comb begin
        case (idex.alu_op)
            ALU_SUB: alu_res = op_a - alu_b;
            ALU_AND: alu_res = op_a & alu_b;
            ALU_OR:  alu_res = op_a | alu_b;
            ALU_XOR: alu_res = op_a ^ alu_b;
            ALU_SLT: alu_res = {{(`XLEN-1){1'b0}}, ($signed(op_a) < $signed(alu_b))};
            default: alu_res = op_a + alu_b;
        endcase
    end

    // ----------------------------------------------------------
    // Branch compare and jump targets
    // ----------------------------------------------------------
    assign equal = (op_a == op_b);
    assign taken = idex.ctrl.branch && (idex.ctrl.bne ? !equal : equal);

    // Bubbles never redirect
    assign redirect = idex.valid && (taken || idex.ctrl.jal || idex.ctrl.jalr);

    // JALR target drops bit 0
    assign jalr_sum = op_a + idex.imm;
    assign target   = idex.ctrl.jalr ? {jalr_sum[`XLEN-1:1], 1'b0} : (idex.pc + idex.imm);

    // Return address for JAL and JALR
    assign link = idex.pc + 32'd4;

    // Record passed on to MEM, a bubble stays all zero
    always_comb begin
        exmem            = '0;
        exmem.valid      = idex.valid;
        exmem.pc         = idex.pc;
        exmem.reg_wr     = idex.reg_wr;
        exmem.result     = (idex.ctrl.jal || idex.ctrl.jalr) ? link : alu_res;
        exmem.store_data = op_b;
        exmem.load       = idex.ctrl.load;
        exmem.store      = idex.ctrl.store;
    end

endmodule

// ==== hazard/hazard_unit.sv ====
`timescale 1ns/1ps

`include "core_settings.svh"

module hazard_unit
    import pipe_pkg::*;
(
    // Decode stage sources
    input  reg_use_t d_use,
    input  logic     d_valid,
    // Execute stage
    input  reg_use_t e_use,
    input  reg_wr_t  e_wr,
    input  logic     e_load,
    // Memory and writeback destinations
    input  reg_wr_t  m_wr,
    input  reg_wr_t  w_wr,
    // Taken branch or jump from execute
    input  logic     redirect,
    // Pipeline control
    output logic     stall,
    output logic     ifid_flush,
    output logic     idex_flush,
    // Operand source selects for execute
    output fwd_sel_e rs1_sel,
    output fwd_sel_e rs2_sel
);

    logic load_use;
    logic wb_dec;

    // True when a live destination matches a nonzero source index
    function automatic logic dest_hits(input reg_wr_t wr, input logic [`REG_W-1:0] rs);
        return wr.we && (wr.rd != '0) && (wr.rd == rs);
    endfunction

    // MEM is younger than WB, so it is checked first
    function automatic fwd_sel_e pick_src(input logic [`REG_W-1:0] rs,
                                          input reg_wr_t mem_wr,
                                          input reg_wr_t wb_wr);
        fwd_sel_e sel;
        if (dest_hits(mem_wr, rs)) begin
            sel = FWD_MEM;
        end else if (dest_hits(wb_wr, rs)) begin
            sel = FWD_WB;
        end else begin
            sel = FWD_IDEX;
        end
        return sel;
    endfunction

    // ----------------------------------------------------------
    // Stall detection
    // ----------------------------------------------------------

    // Load data only arrives in MEM, too late for the next instruction
    assign load_use = d_valid && e_load &&
                      (dest_hits(e_wr, d_use.rs1) || dest_hits(e_wr, d_use.rs2));

    // Regfile has no bypass, so decode waits for the write to land
    assign wb_dec = d_valid &&
                    (dest_hits(w_wr, d_use.rs1) || dest_hits(w_wr, d_use.rs2));

    assign stall = load_use || wb_dec;

    // ----------------------------------------------------------
    // Flushes
    // ----------------------------------------------------------

    // Redirect kills the two younger instructions
    assign ifid_flush = redirect;

    // A stall leaves a bubble behind the held decode slot
    assign idex_flush = redirect || stall;

    // ----------------------------------------------------------
    // Forwarding selects
    // ----------------------------------------------------------
    assign rs1_sel = pick_src(e_use.rs1, m_wr, w_wr);
    assign rs2_sel = pick_src(e_use.rs2, m_wr, w_wr);

endmodule

// ==== rtl/core_top.sv ====
`timescale 1ns/1ps

`include "core_settings.svh"

module core_top
    import rv_isa_pkg::*, pipe_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    output logic [`XLEN-1:0] imem_addr,
    input  logic [`XLEN-1:0] imem_data,
    output dmem_req_t        dmem_req,
    input  logic [`XLEN-1:0] dmem_rdata,
    output retire_t          retire
);

    logic [`XLEN-1:0] pc;

    // Stage register inputs and outputs
    ifid_t            ifid_d;
    ifid_t            ifid_q;
    idex_t            idex_d;
    idex_t            idex_q;
    exmem_t           exmem_d;
    exmem_t           exmem_q;
    memwb_t           memwb_d;
    memwb_t           memwb_q;

    // Decode results
    reg_use_t         dec_use;
    reg_wr_t          dec_wr;
    logic [`XLEN-1:0] dec_imm;
    alu_op_e          dec_alu_op;
    ctrl_t            dec_ctrl;
    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;

    // Hazard and redirect controls
    logic             stall;
    logic             ifid_flush;
    logic             idex_flush;
    fwd_sel_e         rs1_sel;
    fwd_sel_e         rs2_sel;
    logic             redirect;
    logic [`XLEN-1:0] target;

    // Value leaving MEM, load data or ALU result
    logic [`XLEN-1:0] mem_value;

    // ----------------------------------------------------------
    // Fetch
    // ----------------------------------------------------------

    // Redirect wins over stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `RESET_PC;
        end else if (redirect) begin
            pc <= target;
        end else if (!stall) begin
            pc <= pc + 32'd4;
        end
    end

    assign imem_addr = pc;

    always_comb begin
        ifid_d       = '0;
        ifid_d.valid = 1'b1;
        ifid_d.pc    = pc;
        ifid_d.insn  = imem_data;
    end

    pipe_reg #(.T(ifid_t)) ifid_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .hold  (stall),
        .flush (ifid_flush),
        .d     (ifid_d),
        .q     (ifid_q)
    );

    // ----------------------------------------------------------
    // Decode
    // ----------------------------------------------------------
    decoder decoder_i (
        .insn    (ifid_q.insn),
        .dec_use (dec_use),
        .dec_wr  (dec_wr),
        .imm     (dec_imm),
        .alu_op  (dec_alu_op),
        .ctrl    (dec_ctrl)
    );

    // Written from MEM/WB, no bypass to decode
    regfile regfile_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_use  (dec_use),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .wr      (memwb_q.reg_wr),
        .wr_val  (memwb_q.value)
    );

    // A bubble in IF/ID holds a zero word and decodes to all zeros
    always_comb begin
        idex_d         = '0;
        idex_d.valid   = ifid_q.valid;
        idex_d.pc      = ifid_q.pc;
        idex_d.reg_use = dec_use;
        idex_d.reg_wr  = dec_wr;
        idex_d.rs1_val = rs1_val;
        idex_d.rs2_val = rs2_val;
        idex_d.imm     = dec_imm;
        idex_d.alu_op  = dec_alu_op;
        idex_d.ctrl    = dec_ctrl;
    end

    pipe_reg #(.T(idex_t)) idex_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .hold  (1'b0),
        .flush (idex_flush),
        .d     (idex_d),
        .q     (idex_q)
    );

    // ----------------------------------------------------------
    // Hazards and execute
    // ----------------------------------------------------------
    hazard_unit hazard_i (
        .d_use      (dec_use),
        .d_valid    (ifid_q.valid),
        .e_use      (idex_q.reg_use),
        .e_wr       (idex_q.reg_wr),
        .e_load     (idex_q.ctrl.load),
        .m_wr       (exmem_q.reg_wr),
        .w_wr       (memwb_q.reg_wr),
        .redirect   (redirect),
        .stall      (stall),
        .ifid_flush (ifid_flush),
        .idex_flush (idex_flush),
        .rs1_sel    (rs1_sel),
        .rs2_sel    (rs2_sel)
    );

    execute_stage execute_i (
        .idex     (idex_q),
        .rs1_sel  (rs1_sel),
        .rs2_sel  (rs2_sel),
        .mem_fwd  (mem_value),
        .wb_fwd   (memwb_q.value),
        .exmem    (exmem_d),
        .redirect (redirect),
        .target   (target)
    );

    pipe_reg #(.T(exmem_t)) exmem_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .hold  (1'b0),
        .flush (1'b0),
        .d     (exmem_d),
        .q     (exmem_q)
    );

    // ----------------------------------------------------------
    // Memory access
    // ----------------------------------------------------------
    always_comb begin
        dmem_req       = '0;
        dmem_req.addr  = exmem_q.result;
        dmem_req.wdata = exmem_q.store_data;
        dmem_req.we    = exmem_q.store;
        dmem_req.re    = exmem_q.load;
    end

    assign mem_value = exmem_q.load ? dmem_rdata : exmem_q.result;

    always_comb begin
        memwb_d        = '0;
        memwb_d.valid  = exmem_q.valid;
        memwb_d.pc     = exmem_q.pc;
        memwb_d.reg_wr = exmem_q.reg_wr;
        memwb_d.value  = mem_value;
    end

    pipe_reg #(.T(memwb_t)) memwb_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .hold  (1'b0),
        .flush (1'b0),
        .d     (memwb_d),
        .q     (memwb_q)
    );

    // ----------------------------------------------------------
    // Retire
    // ----------------------------------------------------------
    always_comb begin
        retire        = '0;
        retire.valid  = memwb_q.valid;
        retire.pc     = memwb_q.pc;
        retire.reg_wr = memwb_q.reg_wr;
        retire.value  = memwb_q.value;
    end

endmodule

// ==== tests/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic rst_n
);

    // 40 ns period, first rising edge at 20 ns
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Reset low through the first three rising edges
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== tests/core_ref_model.svh ====
`ifndef CORE_REF_MODEL_SVH
`define CORE_REF_MODEL_SVH

// Instruction kinds the generator draws from
typedef enum int {
    K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT, K_ADDI,
    K_LW, K_SW, K_BEQ, K_BNE, K_JAL, K_JALR
} kind_e;

// Program kept as fields, the encoded words go to imem
kind_e             p_kind [0:63];
logic [`REG_W-1:0] p_rd   [0:63];
logic [`REG_W-1:0] p_rs1  [0:63];
logic [`REG_W-1:0] p_rs2  [0:63];
logic [31:0]       p_imm  [0:63];

integer      seed = 32'h882f_7977;
retire_t     exp_ret [$];
logic [63:0] exp_st  [$];
logic [31:0] exp_ld  [$];
logic [31:0] model_mem [0:31];

// Initial data memory word, distinct for every address
function automatic logic [31:0] fill_word(input int idx);
    return 32'h3c00_0000 ^ (idx * 32'h0001_0101);
endfunction

// RV32I encoding of program word i
function automatic logic [31:0] encode(input int i);
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
    rd  = p_rd[i];
    rs1 = p_rs1[i];
    rs2 = p_rs2[i];
    imm = p_imm[i];
    case (p_kind[i])
        K_ADD:  return {F7_BASE, rs2, rs1, F3_ADD, rd, OPC_OP};
        K_SUB:  return {F7_SUB, rs2, rs1, F3_ADD, rd, OPC_OP};
        K_AND:  return {F7_BASE, rs2, rs1, F3_AND, rd, OPC_OP};
        K_OR:   return {F7_BASE, rs2, rs1, F3_OR, rd, OPC_OP};
        K_XOR:  return {F7_BASE, rs2, rs1, F3_XOR, rd, OPC_OP};
        K_SLT:  return {F7_BASE, rs2, rs1, F3_SLT, rd, OPC_OP};
        K_ADDI: return {imm[11:0], rs1, F3_ADD, rd, OPC_OP_IMM};
        K_LW:   return {imm[11:0], rs1, F3_LW, rd, OPC_LOAD};
        K_SW:   return {imm[11:5], rs2, rs1, F3_SW, imm[4:0], OPC_STORE};
        K_BEQ:  return {imm[12], imm[10:5], rs2, rs1, F3_BEQ, imm[4:1], imm[11], OPC_BRANCH};
        K_BNE:  return {imm[12], imm[10:5], rs2, rs1, F3_BNE, imm[4:1], imm[11], OPC_BRANCH};
        K_JAL:  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
        default: return {imm[11:0], rs1, F3_JALR, rd, OPC_JALR};
    endcase
endfunction

// Random program on x0..x7, control flow only goes forward
task automatic gen_program();
    int span;
    for (int i = 0; i < 63; i++) begin
        p_kind[i] = kind_e'($unsigned($random(seed)) % 13);
        p_rd[i]   = 5'($unsigned($random(seed)) % 8);
        p_rs1[i]  = 5'($unsigned($random(seed)) % 8);
        p_rs2[i]  = 5'($unsigned($random(seed)) % 8);
        p_imm[i]  = $random(seed) % 64;
        span      = (63 - i < 4) ? 63 - i : 4;
        // Loads, stores and JALR address off x0
        if (p_kind[i] inside {K_LW, K_SW, K_JALR}) begin
            p_rs1[i] = '0;
        end
        if (p_kind[i] inside {K_LW, K_SW}) begin
            p_imm[i] = 32'(4 * ($unsigned($random(seed)) % 32));
        end else if (p_kind[i] inside {K_BEQ, K_BNE, K_JAL, K_JALR}) begin
            p_imm[i] = 32'(4 * (1 + $unsigned($random(seed)) % span));
        end
        // JALR target is absolute, so add this word's address
        if (p_kind[i] == K_JALR) begin
            p_imm[i] = p_imm[i] + 32'(4 * i);
        end
    end
    // Last word spins on itself
    p_kind[63] = K_JAL;
    p_rd[63]   = '0;
    p_rs1[63]  = '0;
    p_rs2[63]  = '0;
    p_imm[63]  = '0;
    for (int i = 0; i < 64; i++) begin
        imem[i] = encode(i);
    end
endtask

// Architectural run, one expected retire per executed instruction
task automatic run_model();
    logic [31:0] regs [0:31];
    logic [31:0] pc;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] next_pc;
    logic        stop;
    int          w;
    retire_t     rec;
    for (int i = 0; i < 32; i++) begin
        regs[i]      = '0;
        model_mem[i] = fill_word(i);
    end
    pc = `RESET_PC;
    do begin
        w       = int'(pc[7:2]);
        a       = regs[p_rs1[w]];
        b       = regs[p_rs2[w]];
        res     = '0;
        next_pc = pc + 32'd4;
        case (p_kind[w])
            K_ADD:  res = a + b;
            K_SUB:  res = a - b;
            K_AND:  res = a & b;
            K_OR:   res = a | b;
            K_XOR:  res = a ^ b;
            K_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            K_ADDI: res = a + p_imm[w];
            K_LW: begin
                res = model_mem[5'((a + p_imm[w]) >> 2)];
                exp_ld.push_back(a + p_imm[w]);
            end
            K_SW: begin
                model_mem[5'((a + p_imm[w]) >> 2)] = b;
                exp_st.push_back({a + p_imm[w], b});
            end
            K_BEQ:  next_pc = (a == b) ? pc + p_imm[w] : next_pc;
            K_BNE:  next_pc = (a != b) ? pc + p_imm[w] : next_pc;
            K_JAL: begin
                res     = pc + 32'd4;
                next_pc = pc + p_imm[w];
            end
            default: begin
                res     = pc + 32'd4;
                next_pc = (a + p_imm[w]) & ~32'd1;
            end
        endcase
        rec       = '0;
        rec.valid = 1'b1;
        rec.pc    = pc;
        rec.value = res;
        // Stores and branches write nothing, x0 is never written
        if (!(p_kind[w] inside {K_SW, K_BEQ, K_BNE}) && p_rd[w] != '0) begin
            rec.reg_wr.rd = p_rd[w];
            rec.reg_wr.we = 1'b1;
            regs[p_rd[w]] = res;
        end
        exp_ret.push_back(rec);
        // Stop once the self loop has run one pass
        stop = (next_pc == pc);
        pc   = next_pc;
    end while (!stop);
endtask

`endif

// ==== tests/tb_core.sv ====
`timescale 1ns/1ps

`include "core_settings.svh"

module tb_core
    import rv_isa_pkg::*, pipe_pkg::*;
();

    logic             clk;
    logic             rst_n;
    logic [`XLEN-1:0] imem_addr;
    logic [`XLEN-1:0] imem_data;
    dmem_req_t        dmem_req;
    logic [`XLEN-1:0] dmem_rdata;
    retire_t          retire;

    // 64-word program, 32-word data memory
    logic [31:0] imem [0:63];
    logic [31:0] dmem [0:31];

    int   errors;
    int   checks;
    int   n_expected;
    logic model_ready = 1'b0;

    `include "core_ref_model.svh"

    clk_gen clk_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    core_top dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .retire     (retire)
    );

    // ----------------------------------------------------------
    // Memories, combinational read and write on the rising edge
    // ----------------------------------------------------------
    assign imem_data  = imem[imem_addr[7:2]];
    assign dmem_rdata = dmem[dmem_req.addr[6:2]];

    always @(posedge clk) begin
        if (dmem_req.we) begin
            dmem[dmem_req.addr[6:2]] <= dmem_req.wdata;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("error at %0d ns: %s = %h, expected %h", $time, name, got, want);
        end
    endtask

    // ----------------------------------------------------------
    // Test sequence, outputs sampled on the falling edge
    // ----------------------------------------------------------
    initial begin
        int          mark;
        retire_t     want;
        logic [63:0] want_st;
        errors = 0;
        checks = 0;
        gen_program();
        for (int i = 0; i < 32; i++) begin
            dmem[i] <= fill_word(i);
        end
        run_model();
        n_expected  = exp_ret.size();
        model_ready = 1'b1;

        // Nothing retires, reads or writes while in reset
        mark = errors;
        do begin
            @(negedge clk);
            check_value("retire.valid", 32'(retire.valid), 32'd0);
            check_value("dmem_req.we", 32'(dmem_req.we), 32'd0);
            check_value("dmem_req.re", 32'(dmem_req.re), 32'd0);
        end while (!rst_n);
        $display("test reset: %0d errors", errors - mark);

        // Retires, loads and stores, each in program order
        mark = errors;
        while (exp_ret.size() > 0) begin
            @(negedge clk);
            if (dmem_req.we && exp_st.size() == 0) begin
                errors++;
                $display("data memory write at %0d ns that the program never makes", $time);
            end else if (dmem_req.we) begin
                want_st = exp_st.pop_front();
                check_value("dmem_req.addr", dmem_req.addr, want_st[63:32]);
                check_value("dmem_req.wdata", dmem_req.wdata, want_st[31:0]);
            end
            if (dmem_req.re && exp_ld.size() == 0) begin
                errors++;
                $display("data memory read at %0d ns that the program never makes", $time);
            end else if (dmem_req.re) begin
                check_value("dmem_req.addr", dmem_req.addr, exp_ld.pop_front());
            end
            if (retire.valid) begin
                want = exp_ret.pop_front();
                check_value("retire.pc", retire.pc, want.pc);
                check_value("retire.reg_wr.we", 32'(retire.reg_wr.we), 32'(want.reg_wr.we));
                // rd and value only mean something for a register write
                if (want.reg_wr.we) begin
                    check_value("retire.reg_wr.rd", 32'(retire.reg_wr.rd),
                                32'(want.reg_wr.rd));
                    check_value("retire.value", retire.value, want.value);
                end
            end
        end
        $display("test program: %0d retires, %0d errors", n_expected, errors - mark);

        // Every store landed and memory matches the model
        mark = errors;
        repeat (2) @(negedge clk);
        if (exp_st.size() != 0) begin
            errors++;
            $display("%0d expected data memory writes never happened", exp_st.size());
        end
        if (exp_ld.size() != 0) begin
            errors++;
            $display("%0d expected data memory reads never happened", exp_ld.size());
        end
        for (int i = 0; i < 32; i++) begin
            check_value($sformatf("dmem[%0d]", i), dmem[i], model_mem[i]);
        end
        $display("test final state: %0d errors", errors - mark);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Watchdog, 4 cycles per expected retire plus 50 cycles of slack
    initial begin
        wait (model_ready);
        #((n_expected * 4 + 50) * 40);
        $display("timeout: the core did not retire the whole program in time");
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+common
+incdir+tests
common/rv_isa_pkg.sv
common/pipe_pkg.sv
rtl/pipe_reg.sv
rtl/decoder.sv
rtl/regfile.sv
rtl/execute_stage.sv
hazard/hazard_unit.sv
rtl/core_top.sv
tests/clk_gen.sv
tests/tb_core.sv

// ==== Makefile ====
# Verilator build and run of tb_core

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build tb_core with Verilator, run it, fail on a failed run"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --top-module tb_core -f project.f -o sim_core
	./obj_dir/sim_core > sim.log 2>&1; cat sim.log
	@if grep -q -F "*** FAILED ***" sim.log; then exit 1; fi
	@grep -q -F "*** PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log
